//--- flist.f
+incdir+include
src/mips_pkg.sv
src/pc_reg.sv
src/reg_file.sv
src/decode_stage.sv
src/reg_val_mux.sv
src/branch_unit.sv
src/exec_stage.sv
src/mips_core.sv
test/mips_assertions.sv
test/tb_mips_core.sv

//--- test/tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module tb_mips_core import mips_pkg::*; ();

    localparam int    TIMEOUT_CYCLES = 2000;
    localparam word_t HALT_INST      = {`OP_BEQ, 5'd0, 5'd0, 16'hffff};   // Branch to itself

    logic  clk;
    logic  rst_n;
    word_t ibus_address;
    logic  ibus_read;
    word_t ibus_rddata;
    word_t dbus_address;
    word_t dbus_wrdata;
    logic  dbus_read;
    logic  dbus_write;
    word_t dbus_rddata;

    word_t imem [0:255];
    word_t dmem [0:255];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    prog_len;
    string cur_test;
    word_t rng;

    mips_core i_mips_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_address_o (ibus_address),
        .ibus_read_o    (ibus_read),
        .ibus_rddata_i  (ibus_rddata),
        .dbus_address_o (dbus_address),
        .dbus_wrdata_o  (dbus_wrdata),
        .dbus_read_o    (dbus_read),
        .dbus_write_o   (dbus_write),
        .dbus_rddata_i  (dbus_rddata)
    );

    always #4 clk = ~clk;

    assign ibus_rddata = imem[ibus_address[9:2]];
    assign dbus_rddata = dmem[dbus_address[9:2]];

    function automatic word_t fill_word(input int idx);
        logic [7:0] b;
        b = idx[7:0];
        return {b, ~b, b ^ 8'h5a, 8'hc3};
    endfunction

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [5:0] funct);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ISA-level model with one delay slot, collects the expected stores
    function automatic void run_reference();
        word_t regs [0:31];
        word_t mem [0:255];
        word_t pc;
        word_t npc;
        word_t inst;
        word_t a;
        word_t b;
        word_t imm_s;
        word_t addr;
        logic  taken;
        int    i;
        for (i = 0; i < 32; i++) regs[i] = '0;
        for (i = 0; i < 256; i++) mem[i] = fill_word(i);
        pc  = `MIPS_RESET_PC;
        npc = pc + 32'd4;
        for (i = 0; i < 4000; i++) begin
            inst = imem[pc[9:2]];
            if (inst == HALT_INST) break;
            a     = regs[inst[25:21]];
            b     = regs[inst[20:16]];
            imm_s = {{16{inst[15]}}, inst[15:0]};
            addr  = a + imm_s;
            taken = 1'b0;
            case (inst[31:26])
                `OP_RTYPE: begin
                    case (inst[5:0])
                        `FN_ADDU: regs[inst[15:11]] = a + b;
                        `FN_SUBU: regs[inst[15:11]] = a - b;
                        `FN_AND:  regs[inst[15:11]] = a & b;
                        `FN_OR:   regs[inst[15:11]] = a | b;
                        `FN_SLT:  regs[inst[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  ;
                    endcase
                end
                `OP_ADDIU: regs[inst[20:16]] = a + imm_s;
                `OP_LUI:   regs[inst[20:16]] = {inst[15:0], 16'h0000};
                `OP_LW:    regs[inst[20:16]] = mem[addr[9:2]];
                `OP_SW: begin
                    mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                `OP_BEQ:   taken = (a == b);
                `OP_BNE:   taken = (a != b);
                default:   ;
            endcase
            regs[0] = '0;
            pc      = npc;
            npc     = taken ? (pc + (imm_s << 2)) : (npc + 32'd4);   // pc now holds the delay slot
        end
    endfunction

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            fail_stop($sformatf("error test %s expected %h actual %h",
                                test_name, expected, actual));
        end
    endtask

    // Store monitor, also updates the data memory
    always @(negedge clk) begin
        if (rst_n && dbus_write) begin
            if (exp_addr.size() == 0) begin
                fail_stop($sformatf("test %s made a store to %h that was not expected",
                                    cur_test, dbus_address));
            end else begin
                check_value({cur_test, " store address"}, exp_addr[0], dbus_address);
                check_value({cur_test, " store data"}, exp_data[0], dbus_wrdata);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                dmem[dbus_address[9:2]] = dbus_wrdata;
            end
        end
    end

    task automatic start_program();
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = '0;   // Zero word is a no-operation
        prog_len = 0;
    endtask

    task automatic emit(input word_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic run_program(input string name);
        int cycles;
        emit(HALT_INST);
        emit(32'h0);
        cur_test = name;
        for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        run_reference();
        for (cycles = 0; cycles < 3; cycles++) @(posedge clk);
        @(negedge clk);
        check_value({name, " pc in reset"}, `MIPS_RESET_PC, ibus_address);
        check_value({name, " strobes in reset"}, 32'd0, {30'd0, dbus_read, dbus_write});
        @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value({name, " pc after reset"}, `MIPS_RESET_PC, ibus_address);
        check_value({name, " strobes after reset"}, 32'd0, {30'd0, dbus_read, dbus_write});
        check_value({name, " ibus read after reset"}, 32'd1, {31'd0, ibus_read});
        for (cycles = 0; cycles < TIMEOUT_CYCLES && exp_addr.size() != 0; cycles++) begin
            @(posedge clk);
        end
        if (exp_addr.size() != 0) begin
            fail_stop($sformatf("timeout in test %s with %0d stores still missing",
                                name, exp_addr.size()));
        end
        for (cycles = 0; cycles < 16; cycles++) @(posedge clk);   // Catch stray stores
    endtask

    initial begin
        word_t     imm;
        reg_addr_t rd;
        int        kind;
        clk   = 1'b0;
        rst_n = 1'b0;
        rng   = 32'hd816_2966;

        start_program();
        emit(enc_i(`OP_ADDIU, 0, 1, 16'd100));
        emit(enc_i(`OP_ADDIU, 1, 2, 16'd23));   // EX forwarding
        emit(enc_r(1, 2, 3, `FN_ADDU));         // MM and EX forwarding
        emit(enc_r(3, 1, 4, `FN_SUBU));
        emit(enc_i(`OP_SW, 0, 4, 16'h0000));
        emit(enc_i(`OP_LUI, 0, 5, 16'h1234));
        emit(enc_r(5, 4, 6, `FN_OR));
        emit(enc_i(`OP_SW, 0, 6, 16'h0004));
        emit(enc_i(`OP_ADDIU, 0, 9, 16'hfffb));
        emit(enc_r(9, 1, 7, `FN_SLT));
        emit(enc_r(1, 9, 8, `FN_SLT));
        emit(enc_r(6, 3, 10, `FN_AND));
        emit(enc_r(9, 3, 11, `FN_SUBU));
        emit(enc_i(`OP_ADDIU, 0, 12, 16'h0040));
        emit(enc_i(`OP_SW, 12, 11, 16'h0000));  // Base forwarded from EX
        emit(enc_i(`OP_SW, 0, 2, 16'h0008));
        emit(enc_i(`OP_SW, 0, 3, 16'h000c));
        emit(enc_i(`OP_SW, 0, 7, 16'h0010));
        emit(enc_i(`OP_SW, 0, 8, 16'h0014));
        emit(enc_i(`OP_SW, 0, 10, 16'h0018));
        emit(enc_i(`OP_SW, 0, 5, 16'h001c));
        run_program("forwarding");

        start_program();
        emit(enc_i(`OP_ADDIU, 0, 1, 16'h0040));
        emit(enc_i(`OP_ADDIU, 0, 2, 16'h1357));
        emit(enc_i(`OP_SW, 1, 2, 16'h0000));
        emit(enc_i(`OP_ADDIU, 0, 3, 16'hfffe));
        emit(enc_i(`OP_SW, 1, 3, 16'h0004));
        emit(enc_i(`OP_LW, 1, 4, 16'h0000));
        emit(enc_i(`OP_ADDIU, 0, 6, 16'd7));    // Independent slot after the load
        emit(enc_r(4, 6, 5, `FN_ADDU));
        emit(enc_i(`OP_LW, 1, 7, 16'h0004));
        emit(enc_i(`OP_ADDIU, 0, 8, 16'd1));
        emit(enc_i(`OP_SW, 1, 7, 16'h0008));
        emit(enc_i(`OP_SW, 1, 5, 16'h000c));
        emit(enc_i(`OP_LW, 0, 9, 16'h0080));    // Preloaded word
        emit(enc_i(`OP_ADDIU, 0, 10, 16'd3));
        emit(enc_i(`OP_SW, 1, 9, 16'h0020));
        run_program("memory");

        start_program();
        emit(enc_i(`OP_ADDIU, 0, 1, 16'd5));
        emit(enc_i(`OP_ADDIU, 0, 2, 16'd5));
        emit(enc_i(`OP_ADDIU, 0, 3, 16'd9));
        emit(enc_i(`OP_BEQ, 1, 2, 16'd2));      // Taken
        emit(enc_i(`OP_SW, 0, 1, 16'h0000));
        emit(enc_i(`OP_SW, 0, 3, 16'h0004));
        emit(enc_i(`OP_SW, 0, 2, 16'h0008));
        emit(enc_i(`OP_BNE, 1, 2, 16'd2));      // Not taken
        emit(enc_i(`OP_SW, 0, 3, 16'h000c));
        emit(enc_i(`OP_SW, 0, 1, 16'h0010));
        emit(enc_i(`OP_ADDIU, 0, 4, 16'd9));
        emit(enc_i(`OP_BNE, 4, 3, 16'd2));
        emit(enc_i(`OP_SW, 0, 4, 16'h0014));
        emit(enc_i(`OP_BEQ, 1, 3, 16'd2));
        emit(enc_i(`OP_SW, 0, 3, 16'h0018));
        emit(enc_i(`OP_SW, 0, 1, 16'h001c));
        emit(enc_i(`OP_BNE, 1, 3, 16'd2));      // Taken
        emit(enc_i(`OP_ADDIU, 0, 6, 16'd77));
        emit(enc_i(`OP_SW, 0, 1, 16'h0020));
        emit(enc_i(`OP_SW, 0, 6, 16'h0024));
        emit(enc_i(`OP_ADDIU, 0, 5, 16'd3));
        emit(enc_i(`OP_ADDIU, 5, 5, 16'hffff));
        emit(enc_i(`OP_BNE, 5, 0, 16'hfffe));   // Backward loop
        emit(enc_i(`OP_SW, 0, 5, 16'h0028));
        emit(enc_i(`OP_SW, 0, 5, 16'h002c));
        run_program("branches");

        start_program();
        for (int n = 0; n < 40; n++) begin
            rng  = xorshift32(rng);
            kind = int'(rng % 32'd7);
            rd   = (rng[12:8] == 5'd0) ? 5'd1 : rng[12:8];
            imm  = xorshift32(rng);
            case (kind)
                0: emit(enc_r(rng[17:13], rng[22:18], rd, `FN_ADDU));
                1: emit(enc_r(rng[17:13], rng[22:18], rd, `FN_SUBU));
                2: emit(enc_r(rng[17:13], rng[22:18], rd, `FN_AND));
                3: emit(enc_r(rng[17:13], rng[22:18], rd, `FN_OR));
                4: emit(enc_r(rng[17:13], rng[22:18], rd, `FN_SLT));
                5: emit(enc_i(`OP_ADDIU, rng[17:13], rd, imm[15:0]));
                default: emit(enc_i(`OP_LUI, 5'd0, rd, imm[15:0]));
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            emit(enc_i(`OP_SW, 5'd0, r[4:0], 16'h0200 + 16'(r * 4)));
        end
        run_program("random");

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mips_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module mips_assertions import mips_pkg::*; (
    input wire        clk,
    input wire        rst_n,
    input wire        dbus_read_i,
    input wire        dbus_write_i,
    input wire word_t dbus_address_i
);

    // One data access per cycle
    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_read_i && dbus_write_i))
        else $error("dbus read and write strobes high together");

    strobes_idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!dbus_read_i && !dbus_write_i))
        else $error("dbus strobe high during reset");

    dbus_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_read_i || dbus_write_i) |-> (dbus_address_i[1:0] == 2'b00))
        else $error("dbus address not word aligned");

endmodule

bind mips_core mips_assertions i_mips_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .dbus_read_i    (dbus_read_o),
    .dbus_write_i   (dbus_write_o),
    .dbus_address_i (dbus_address_o)
);

`default_nettype wire

//--- src/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core import mips_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    output word_t      ibus_address_o,
    output logic       ibus_read_o,
    input  wire word_t ibus_rddata_i,
    output word_t      dbus_address_o,
    output word_t      dbus_wrdata_o,
    output logic       dbus_read_o,
    output logic       dbus_write_o,
    input  wire word_t dbus_rddata_i
);

    word_t     if_pc;
    word_t     id_inst;
    word_t     id_pc;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    word_t     id_rs_regs;
    word_t     id_rt_regs;
    word_t     id_rs_value;
    word_t     id_rt_value;
    id_ex_t    id_ctrl_dec;
    id_ex_t    id_ctrl;
    logic      id_branch_taken;
    word_t     id_branch_target;
    id_ex_t    id_ex_q;
    ex_mm_t    ex_out;
    ex_mm_t    ex_mm_q;
    mm_wb_t    mm_out;
    mm_wb_t    mm_wb_q;

    pc_reg i_pc_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .branch_taken_i  (id_branch_taken),
        .branch_target_i (id_branch_target),
        .pc_o            (if_pc)
    );

    assign ibus_address_o = if_pc;
    assign ibus_read_o    = 1'b1;      // Fetch runs every cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_inst <= '0;             // All-zero word decodes as a no-operation
            id_pc   <= '0;
        end else begin
            id_inst <= ibus_rddata_i;
            id_pc   <= if_pc;
        end
    end

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .we_i      (mm_wb_q.reg_write),
        .waddr_i   (mm_wb_q.dest),
        .wdata_i   (mm_wb_q.wdata),
        .rdata_a_o (id_rs_regs),
        .rdata_b_o (id_rt_regs)
    );

    decode_stage i_decode_stage (
        .inst_i (id_inst),
        .rs_o   (id_rs),
        .rt_o   (id_rt),
        .ctrl_o (id_ctrl_dec)
    );

    reg_val_mux i_reg_val_mux_s (
        .addr_i       (id_rs),
        .regs_value_i (id_rs_regs),
        .ex_fwd_i     (ex_out),
        .mm_fwd_i     (mm_out),
        .value_o      (id_rs_value)
    );

    reg_val_mux i_reg_val_mux_t (
        .addr_i       (id_rt),
        .regs_value_i (id_rt_regs),
        .ex_fwd_i     (ex_out),
        .mm_fwd_i     (mm_out),
        .value_o      (id_rt_value)
    );

    branch_unit i_branch_unit (
        .inst_i     (id_inst),
        .pc_i       (id_pc),
        .rs_value_i (id_rs_value),
        .rt_value_i (id_rt_value),
        .taken_o    (id_branch_taken),
        .target_o   (id_branch_target)
    );

    always_comb begin
        id_ctrl          = id_ctrl_dec;
        id_ctrl.rs_value = id_rs_value;
        id_ctrl.rt_value = id_rt_value;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ctrl;
        end
    end

    exec_stage i_exec_stage (
        .ctrl_i (id_ex_q),
        .out_o  (ex_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mm_q <= '0;
        end else begin
            ex_mm_q <= ex_out;
        end
    end

    assign dbus_address_o = ex_mm_q.result;
    assign dbus_wrdata_o  = ex_mm_q.store_data;
    assign dbus_read_o    = ex_mm_q.mem_read;
    assign dbus_write_o   = ex_mm_q.mem_write;

    // Load data or ALU result, also the MM forwarding value
    always_comb begin
        mm_out.wdata     = ex_mm_q.mem_read ? dbus_rddata_i : ex_mm_q.result;
        mm_out.dest      = ex_mm_q.dest;
        mm_out.reg_write = ex_mm_q.reg_write;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_wb_q <= '0;
        end else begin
            mm_wb_q <= mm_out;
        end
    end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module exec_stage import mips_pkg::*; (
    input  wire id_ex_t ctrl_i,
    output ex_mm_t      out_o
);

    word_t imm_ext;
    word_t op_b;
    word_t alu_res;

    assign imm_ext = ctrl_i.sign_ext ? {{16{ctrl_i.imm[15]}}, ctrl_i.imm} :
                                       {16'b0, ctrl_i.imm};
    assign op_b    = ctrl_i.use_imm ? imm_ext : ctrl_i.rt_value;

    always_comb begin
        case (ctrl_i.alu_op)
            `ALU_ADD: alu_res = ctrl_i.rs_value + op_b;
            `ALU_SUB: alu_res = ctrl_i.rs_value - op_b;
            `ALU_AND: alu_res = ctrl_i.rs_value & op_b;
            `ALU_OR:  alu_res = ctrl_i.rs_value | op_b;
            `ALU_SLT: alu_res = {31'b0, ($signed(ctrl_i.rs_value) < $signed(op_b))};
            `ALU_LUI: alu_res = {ctrl_i.imm, 16'b0};
            default:  alu_res = '0;
        endcase
    end

    // Loads and stores use the sum as the address
    always_comb begin
        out_o.result     = alu_res;
        out_o.store_data = ctrl_i.rt_value;
        out_o.dest       = ctrl_i.dest;
        out_o.reg_write  = ctrl_i.reg_write;
        out_o.mem_read   = ctrl_i.mem_read;
        out_o.mem_write  = ctrl_i.mem_write;
    end

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module branch_unit import mips_pkg::*; (
    input  wire word_t inst_i,
    input  wire word_t pc_i,
    input  wire word_t rs_value_i,
    input  wire word_t rt_value_i,
    output logic       taken_o,
    output word_t      target_o
);

    logic [5:0] opcode;
    logic       equal;
    word_t      offset;

    assign opcode = inst_i[31:26];
    assign equal  = (rs_value_i == rt_value_i);
    assign offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

    assign taken_o  = ((opcode == `OP_BEQ) && equal) ||
                      ((opcode == `OP_BNE) && !equal);
    assign target_o = pc_i + 32'd4 + offset;    // Relative to the delay slot

endmodule

`default_nettype wire

//--- src/reg_val_mux.sv
`timescale 1ns/100ps
`default_nettype none

module reg_val_mux import mips_pkg::*; (
    input  wire reg_addr_t addr_i,
    input  wire word_t     regs_value_i,
    input  wire ex_mm_t    ex_fwd_i,
    input  wire mm_wb_t    mm_fwd_i,
    output word_t          value_o
);

    logic ex_hit;
    logic mm_hit;

    // A load in EX has no data yet
    assign ex_hit = ex_fwd_i.reg_write && !ex_fwd_i.mem_read &&
                    (ex_fwd_i.dest != '0) && (ex_fwd_i.dest == addr_i);
    assign mm_hit = mm_fwd_i.reg_write &&
                    (mm_fwd_i.dest != '0) && (mm_fwd_i.dest == addr_i);

    assign value_o = ex_hit ? ex_fwd_i.result :
                     mm_hit ? mm_fwd_i.wdata  : regs_value_i;

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module decode_stage import mips_pkg::*; (
    input  wire word_t inst_i,
    output reg_addr_t  rs_o,
    output reg_addr_t  rt_o,
    output id_ex_t     ctrl_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];
    assign rd     = inst_i[15:11];

    always_comb begin
        ctrl_o        = '0;            // No-operation unless recognized
        ctrl_o.alu_op = `ALU_ADD;
        ctrl_o.imm    = inst_i[15:0];
        case (opcode)
            `OP_RTYPE: begin
                ctrl_o.dest      = rd;
                ctrl_o.reg_write = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl_o.alu_op = `ALU_ADD;
                    `FN_SUBU: ctrl_o.alu_op = `ALU_SUB;
                    `FN_AND:  ctrl_o.alu_op = `ALU_AND;
                    `FN_OR:   ctrl_o.alu_op = `ALU_OR;
                    `FN_SLT:  ctrl_o.alu_op = `ALU_SLT;
                    default:  ctrl_o.reg_write = 1'b0;
                endcase
            end
            `OP_ADDIU, `OP_LW: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.sign_ext  = 1'b1;
                ctrl_o.dest      = rt_o;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.mem_read  = (opcode == `OP_LW);
            end
            `OP_LUI: begin
                ctrl_o.alu_op    = `ALU_LUI;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.dest      = rt_o;
                ctrl_o.reg_write = 1'b1;
            end
            `OP_SW: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.sign_ext  = 1'b1;
                ctrl_o.mem_write = 1'b1;
            end
            default: begin
                ctrl_o.reg_write = 1'b0;   // Branches finish in decode
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module reg_file import mips_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t raddr_a_i,
    input  wire reg_addr_t raddr_b_i,
    input  wire            we_i,
    input  wire reg_addr_t waddr_i,
    input  wire word_t     wdata_i,
    output word_t          rdata_a_o,
    output word_t          rdata_b_o
);

    word_t regs [0:`MIPS_NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so decode sees the value retiring in this cycle
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- src/pc_reg.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module pc_reg import mips_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        branch_taken_i,
    input  wire word_t branch_target_i,
    output word_t      pc_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o <= `MIPS_RESET_PC;
        end else if (branch_taken_i) begin
            pc_o <= branch_target_i;   // Resolved in decode, after the delay slot fetch
        end else begin
            pc_o <= pc_o + 32'd4;
        end
    end

endmodule

`default_nettype wire

//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    // Decode to execute, operands already forwarded
    typedef struct packed {
        alu_op_t     alu_op;
        word_t       rs_value;
        word_t       rt_value;
        logic [15:0] imm;
        logic        use_imm;
        logic        sign_ext;
        reg_addr_t   dest;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } id_ex_t;

    typedef struct packed {
        word_t       result;        // ALU value or memory address
        word_t       store_data;
        reg_addr_t   dest;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } ex_mm_t;

    typedef struct packed {
        word_t       wdata;
        reg_addr_t   dest;
        logic        reg_write;
    } mm_wb_t;

endpackage

`default_nettype wire

//--- include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define OP_RTYPE  6'h00
`define OP_ADDIU  6'h09
`define OP_LUI    6'h0f
`define OP_LW     6'h23
`define OP_SW     6'h2b
`define OP_BEQ    6'h04
`define OP_BNE    6'h05

`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_SLT   4'd4
`define ALU_LUI   4'd5

`define MIPS_RESET_PC  32'h0000_0000
`define MIPS_NUM_REGS  32

`endif
